/* hdl/game_params.svh */
// Constants of the jump game motion core
// Screen geometry, object sizes, start positions, motion steps
// and the jump key scan code

`ifndef GAME_PARAMS_SVH
`define GAME_PARAMS_SVH

// ------------------------------------------------------------
// Player and floor
// ------------------------------------------------------------
`define PLAYER_X        100      // Player left edge, fixed
`define PLAYER_SIZE     15       // Square player box
`define FLOOR_Y         400      // Floor line, objects rest on it

// ------------------------------------------------------------
// Jump
// ------------------------------------------------------------
`define JUMP_KEY        8'h1A    // W key
`define JUMP_STEP       5        // Rise and fall speed
`define JUMP_HEIGHT     100      // Apex above take-off point

// ------------------------------------------------------------
// Scrolling objects
// ------------------------------------------------------------
`define SCROLL_STEP     3        // Left shift per frame
`define SPIKE_SIZE      32
`define PLATFORM_SIZE   28
`define SPIKE_START     500      // Left edges after reset
`define PLATFORM_START  300
`define FINISH_START    620

`endif

/* hdl/gamePkg.sv */
// Shared types of the jump game motion core
// Screen coordinate, vertical velocity and keyboard scan code

package gamePkg;

    // ------------------------------------------------------------
    // Positions and motion
    // ------------------------------------------------------------
    typedef logic signed [10:0] coord_t;     // Screen pixel, negative is off the left edge
    typedef logic signed [7:0]  velocity_t;  // Vertical pixels per frame, negative rises

    // ------------------------------------------------------------
    // Keyboard
    // ------------------------------------------------------------
    typedef logic [7:0] keycode_t;           // Scan code from the keyboard controller

endpackage

/* hdl/playerJump.sv */
// Vertical motion of the player
// Jump start on the floor, rise to a fixed apex above take-off,
// fall back and land on the ground position
// Registers for position, velocity and apex
`timescale 1ns/1ns
`include "game_params.svh"

module playerJump
(
    input  logic              Reset,      // Frame clock
    input  logic              frame_clk,  // Async reset, active high
    input  gamePkg::keycode_t keycode,    // Current scan code
    input  logic              pause,
    input  logic              halt,       // Game result latched
    output gamePkg::coord_t   playerY     // Top edge of the player
);

    // Top edge of a player standing on the floor
    localparam gamePkg::coord_t groundY = gamePkg::coord_t'(`FLOOR_Y - `PLAYER_SIZE);

    gamePkg::velocity_t velocity;         // Held velocity, applied on the next edge
    gamePkg::coord_t    apex;             // Highest top edge of the current jump
    gamePkg::coord_t    movedY;           // Position after applying held velocity
    gamePkg::coord_t    nextY;
    gamePkg::velocity_t nextVel;
    gamePkg::coord_t    nextApex;
    logic               frozen;
    logic               jumpStart;

    assign frozen    = pause | halt;
    assign movedY    = playerY + gamePkg::coord_t'(velocity);  // Sign extended step
    assign jumpStart = (playerY == groundY) && (velocity == '0) &&
                       (keycode == `JUMP_KEY);

    // ------------------------------------------------------------
    // Next state, jump start beats landing
    // ------------------------------------------------------------
    always_comb
    begin
        nextY    = movedY;                // Old velocity moves the player
        nextVel  = velocity;
        nextApex = apex;
        if (jumpStart)
        begin
            nextVel  = gamePkg::velocity_t'(-`JUMP_STEP);          // Start rising
            nextApex = playerY - gamePkg::coord_t'(`JUMP_HEIGHT);  // Apex above take-off
        end
        else if ((velocity < 0) && (movedY <= apex))
        begin
            nextVel = gamePkg::velocity_t'(`JUMP_STEP);  // Apex reached, turn around
        end
        else if (movedY >= groundY)
        begin
            nextY   = groundY;            // Clamp on the floor
            nextVel = '0;                 // Landed
        end
    end

    // ------------------------------------------------------------
    // State registers, one update per frame
    // ------------------------------------------------------------
    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            playerY  <= groundY;          // Start standing on the floor
            velocity <= '0;
            apex     <= groundY;
        end
        else if (!frozen)
        begin
            playerY  <= nextY;
            velocity <= nextVel;
            apex     <= nextApex;
        end
    end

    // Player never sinks below the floor, whatever the key history
    floorLimit: assert property (@(posedge Reset) disable iff (frame_clk)
        playerY <= groundY);

endmodule

/* hdl/obstacleScroll.sv */
// Horizontal scrolling of spike, platform and finish line
// All three share one step so their spacing never changes
// Motion only with gameplay on and neither pause nor halt
`timescale 1ns/1ns
`include "game_params.svh"

module obstacleScroll
(
    input  logic            Reset,      // Frame clock
    input  logic            frame_clk,  // Async reset, active high
    input  logic            pause,
    input  logic            gameplay,   // Scrolling enabled
    input  logic            halt,       // Game result latched
    output gamePkg::coord_t spikeX,     // Left edges
    output gamePkg::coord_t platformX,
    output gamePkg::coord_t finishX
);

    localparam gamePkg::coord_t scrollStep = gamePkg::coord_t'(`SCROLL_STEP);

    logic            frozen;
    logic            moving;
    gamePkg::coord_t stepX;               // Shared left shift of this frame

    assign frozen = pause | halt;
    assign moving = gameplay & ~frozen;
    assign stepX  = moving ? scrollStep : '0;

    // ------------------------------------------------------------
    // Position registers
    // ------------------------------------------------------------
    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            spikeX    <= gamePkg::coord_t'(`SPIKE_START);
            platformX <= gamePkg::coord_t'(`PLATFORM_START);
            finishX   <= gamePkg::coord_t'(`FINISH_START);
        end
        else
        begin
            spikeX    <= spikeX - stepX;   // Lockstep, same step for all
            platformX <= platformX - stepX;
            finishX   <= finishX - stepX;
        end
    end

    // Pause or a latched result holds every position on the next frame
    holdWhileFrozen: assert property (@(posedge Reset) disable iff (frame_clk)
        frozen |=> ($stable(spikeX) && $stable(platformX) && $stable(finishX)));

endmodule

/* hdl/collisionJudge.sv */
// Collision judge of the jump game
// Box overlap of the player with spike and platform, finish test,
// latched gameOver and won flags and the halt that freezes motion
`timescale 1ns/1ns
`include "game_params.svh"

module collisionJudge
(
    input  logic            Reset,      // Frame clock
    input  logic            frame_clk,  // Async reset, active high
    input  gamePkg::coord_t playerY,    // Player top edge
    input  gamePkg::coord_t spikeX,     // Obstacle left edges
    input  gamePkg::coord_t platformX,
    input  gamePkg::coord_t finishX,
    output logic            gameOver,
    output logic            won,
    output logic            halt        // Freeze for both movers
);

    logic spikeHit;
    logic platformHit;
    logic finishReached;

    // Two half-open spans [lo, lo+len) share at least one pixel
    function automatic logic spanOverlap(input int aLo, input int aLen,
                                         input int bLo, input int bLen);
        return (aLo < bLo + bLen) && (bLo < aLo + aLen);
    endfunction

    // ------------------------------------------------------------
    // Overlap tests, obstacles rest on the floor
    // ------------------------------------------------------------
    assign spikeHit = spanOverlap(`PLAYER_X, `PLAYER_SIZE, spikeX, `SPIKE_SIZE) &&
                      spanOverlap(playerY, `PLAYER_SIZE,
                                  `FLOOR_Y - `SPIKE_SIZE, `SPIKE_SIZE);
    assign platformHit = spanOverlap(`PLAYER_X, `PLAYER_SIZE, platformX, `PLATFORM_SIZE) &&
                         spanOverlap(playerY, `PLAYER_SIZE,
                                     `FLOOR_Y - `PLATFORM_SIZE, `PLATFORM_SIZE);
    assign finishReached = (finishX <= `PLAYER_X);  // Signed, finish may be off screen

    // ------------------------------------------------------------
    // Result latch, contact beats finish
    // ------------------------------------------------------------
    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            gameOver <= 1'b0;
            won      <= 1'b0;
            halt     <= 1'b0;
        end
        else if (!halt)                   // First result wins, then frozen
        begin
            if (spikeHit || platformHit)
            begin
                gameOver <= 1'b1;
                halt     <= 1'b1;
            end
            else if (finishReached)
            begin
                won  <= 1'b1;
                halt <= 1'b1;
            end
        end
    end

    // A game has one result only
    resultExclusive: assert property (@(posedge Reset) disable iff (frame_clk)
        !(gameOver && won));

    // Results stay until reset
    resultSticky: assert property (@(posedge Reset) disable iff (frame_clk)
        (gameOver |=> gameOver) and (won |=> won));

endmodule

/* hdl/gameTop.sv */
// Top level of the jump game motion core
// Player mover, obstacle scroller and collision judge
// Judge halt feeds back to both movers
`timescale 1ns/1ns
`include "game_params.svh"

module gameTop
(
    input  logic              Reset,      // Frame clock, one edge per frame
    input  logic              frame_clk,  // Async reset, active high
    input  gamePkg::keycode_t keycode,    // Keyboard scan code
    input  logic              pause,      // Holds every position
    input  logic              gameplay,   // Scrolling enabled
    output gamePkg::coord_t   playerY,    // Player top edge
    output gamePkg::coord_t   spikeX,     // Obstacle left edges
    output gamePkg::coord_t   platformX,
    output gamePkg::coord_t   finishX,
    output logic              gameOver,   // Contact with an obstacle
    output logic              won         // Finish line reached
);

    logic halt;                           // Either result latched

    // ------------------------------------------------------------
    // Movers
    // ------------------------------------------------------------
    playerJump playerJump_i
    (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .keycode   (keycode),
        .pause     (pause),
        .halt      (halt),
        .playerY   (playerY)
    );

    obstacleScroll obstacleScroll_i
    (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .pause     (pause),
        .gameplay  (gameplay),
        .halt      (halt),
        .spikeX    (spikeX),
        .platformX (platformX),
        .finishX   (finishX)
    );

    // ------------------------------------------------------------
    // Judge
    // ------------------------------------------------------------
    collisionJudge collisionJudge_i
    (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .playerY   (playerY),
        .spikeX    (spikeX),
        .platformX (platformX),
        .finishX   (finishX),
        .gameOver  (gameOver),
        .won       (won),
        .halt      (halt)
    );

endmodule

/* dv/gameTb.sv */
// Testbench of the jump game motion core
// Frame clock and reset, directed and random stimulus,
// per-frame reference model, compare process and final report
`timescale 1ns/1ns
`include "game_params.svh"

module gameTb;

    // Model state, one frame of the game
    typedef struct packed {
        int playerY;
        int velocity;
        int apex;
        int spikeX;
        int platformX;
        int finishX;
        bit gameOver;
        bit won;
        bit halt;
    } frameState_t;

    logic              Reset;             // Frame clock
    logic              frame_clk;         // Async reset, active high
    gamePkg::keycode_t keycode;
    logic              pause;
    logic              gameplay;
    gamePkg::coord_t   playerY;
    gamePkg::coord_t   spikeX;
    gamePkg::coord_t   platformX;
    gamePkg::coord_t   finishX;
    logic              gameOver;
    logic              won;

    frameState_t model;
    int          errorCount = 0;
    int          checkCount = 0;
    int          testCount  = 0;
    int          testErrors0;             // Error count at test start

    gameTop dut_i (.*);

    always #20 Reset = ~Reset;            // 40 ns frame

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic frameState_t startState();
        frameState_t s;
        s = '0;
        s.playerY   = `FLOOR_Y - `PLAYER_SIZE;
        s.apex      = `FLOOR_Y - `PLAYER_SIZE;
        s.spikeX    = `SPIKE_START;
        s.platformX = `PLATFORM_START;
        s.finishX   = `FINISH_START;
        return s;
    endfunction

    function automatic frameState_t stepFrame(frameState_t s, logic [7:0] key,
                                              logic pauseIn, logic playIn);
        frameState_t n;
        int          groundY;
        int          movedY;
        bit          frozen;
        bit          spikeContact;
        bit          platformContact;
        n       = s;
        groundY = `FLOOR_Y - `PLAYER_SIZE;
        frozen  = pauseIn || s.halt;
        // Judge looks at the positions held before this edge
        spikeContact = (s.spikeX < `PLAYER_X + `PLAYER_SIZE) &&
                       (s.spikeX + `SPIKE_SIZE > `PLAYER_X) &&
                       (s.playerY + `PLAYER_SIZE > `FLOOR_Y - `SPIKE_SIZE) &&
                       (s.playerY < `FLOOR_Y);
        platformContact = (s.platformX < `PLAYER_X + `PLAYER_SIZE) &&
                          (s.platformX + `PLATFORM_SIZE > `PLAYER_X) &&
                          (s.playerY + `PLAYER_SIZE > `FLOOR_Y - `PLATFORM_SIZE) &&
                          (s.playerY < `FLOOR_Y);
        if (!s.halt && (spikeContact || platformContact))
            {n.gameOver, n.halt} = 2'b11;  // Contact first
        else if (!s.halt && (s.finishX <= `PLAYER_X))
            {n.won, n.halt} = 2'b11;
        if (!frozen)
        begin
            movedY    = s.playerY + s.velocity;
            n.playerY = movedY;
            if ((s.playerY == groundY) && (s.velocity == 0) && (key == `JUMP_KEY))
            begin
                n.velocity = -`JUMP_STEP;  // Take-off, no move yet
                n.apex     = s.playerY - `JUMP_HEIGHT;
            end
            else if ((s.velocity < 0) && (movedY <= s.apex))
                n.velocity = `JUMP_STEP;
            else if (movedY >= groundY)
            begin
                n.playerY  = groundY;     // Landing
                n.velocity = 0;
            end
        end
        if (playIn && !frozen)
        begin
            n.spikeX    = s.spikeX - `SCROLL_STEP;
            n.platformX = s.platformX - `SCROLL_STEP;
            n.finishX   = s.finishX - `SCROLL_STEP;
        end
        return n;
    endfunction

    always @(posedge Reset)
    begin
        if (frame_clk)
            model = startState();
        else
            model = stepFrame(model, keycode, pause, gameplay);
    end

    // ------------------------------------------------------------
    // Compare process, mid-frame where outputs are settled
    // ------------------------------------------------------------
    task automatic compareSignal(input string name, input int got, input int exp);
        checkCount++;
        if (got != exp)
        begin
            errorCount++;
            $display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    always @(negedge Reset)
    begin
        if (!frame_clk)
        begin
            compareSignal("playerY", int'(playerY), model.playerY);
            compareSignal("spikeX", int'(spikeX), model.spikeX);
            compareSignal("platformX", int'(platformX), model.platformX);
            compareSignal("finishX", int'(finishX), model.finishX);
            compareSignal("gameOver", int'(gameOver), int'(model.gameOver));
            compareSignal("won", int'(won), int'(model.won));
        end
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    task automatic nextFrame();
        @(posedge Reset);
        #2;                               // Inputs change just after the edge
    endtask

    task automatic applyReset();
        frame_clk = 1'b1;
        repeat (4) nextFrame();
        frame_clk = 1'b0;
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("Test %0d %s: %0d errors", testCount, name, errorCount - testErrors0);
        testErrors0 = errorCount;
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial
    begin
        int              frames;
        gamePkg::coord_t heldFinish;
        gamePkg::coord_t heldPlatform;
        Reset       = 1'b0;
        frame_clk   = 1'b1;
        keycode     = '0;
        pause       = 1'b0;
        gameplay    = 1'b0;
        testErrors0 = 0;
        void'($urandom(32'h3dec));        // One seed for the whole run

        applyReset();
        compareSignal("playerY", int'(playerY), `FLOOR_Y - `PLAYER_SIZE);
        compareSignal("spikeX", int'(spikeX), `SPIKE_START);
        compareSignal("platformX", int'(platformX), `PLATFORM_START);
        compareSignal("finishX", int'(finishX), `FINISH_START);
        compareSignal("gameOver", int'(gameOver), 0);
        compareSignal("won", int'(won), 0);
        finishTest("reset values");

        gameplay = 1'b1;
        repeat (10) nextFrame();
        compareSignal("spikeX", int'(spikeX), `SPIKE_START - 10 * `SCROLL_STEP);
        compareSignal("platformX", int'(platformX), `PLATFORM_START - 10 * `SCROLL_STEP);
        compareSignal("finishX", int'(finishX), `FINISH_START - 10 * `SCROLL_STEP);
        pause = 1'b1;
        repeat (5) nextFrame();
        compareSignal("spikeX", int'(spikeX), `SPIKE_START - 10 * `SCROLL_STEP);
        compareSignal("finishX", int'(finishX), `FINISH_START - 10 * `SCROLL_STEP);
        pause    = 1'b0;
        gameplay = 1'b0;
        finishTest("scroll and pause");

        keycode = `JUMP_KEY;              // One frame press on the floor
        nextFrame();
        keycode = '0;
        for (int i = 1; i <= 20; i++)
        begin
            nextFrame();
            compareSignal("playerY", int'(playerY), `FLOOR_Y - `PLAYER_SIZE - 5 * i);
        end
        for (int i = 1; i <= 25; i++)     // Fall, then stay on the floor
        begin
            nextFrame();
            compareSignal("playerY", int'(playerY),
                          `FLOOR_Y - `PLAYER_SIZE - `JUMP_HEIGHT + 5 * (i > 20 ? 20 : i));
        end
        finishTest("jump arc");

        gameplay = 1'b1;
        frames   = 0;
        while (!gameOver && !won && frames < 100)
        begin
            nextFrame();
            frames++;
        end
        if (!gameOver)
        begin
            errorCount++;
            $display("Error: gameOver did not rise within 100 frames of platform approach");
        end
        compareSignal("won", int'(won), 0);
        heldFinish   = finishX;
        heldPlatform = platformX;
        repeat (3) nextFrame();
        compareSignal("finishX (frozen)", int'(finishX), int'(heldFinish));
        compareSignal("platformX (frozen)", int'(platformX), int'(heldPlatform));
        finishTest("platform collision");

        gameplay = 1'b0;
        applyReset();
        gameplay = 1'b1;
        frames   = 0;
        while (!gameOver && !won && frames < 600)
        begin
            keycode = ($urandom % 6 == 0) ? `JUMP_KEY : 8'($urandom_range(255));
            pause   = ($urandom % 10 == 0);
            nextFrame();
            frames++;
        end
        pause = 1'b0;
        if (!gameOver && !won)
        begin
            errorCount++;
            $display("Error: no game result within 600 frames of random play");
        end
        if (won)
        begin
            compareSignal("gameOver", int'(gameOver), 0);
            if (finishX > `PLAYER_X)
            begin
                errorCount++;
                $display("Error: won is set while the finish line is still right of the player");
            end
        end
        $display("Random run ended after %0d frames, gameOver %0d, won %0d",
                 frames, gameOver, won);
        finishTest("random play");

        $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* build.f */
+incdir+hdl
hdl/gamePkg.sv
hdl/playerJump.sv
hdl/obstacleScroll.sv
hdl/collisionJudge.sv
hdl/gameTop.sv
dv/gameTb.sv

/* Makefile */
# Verilator build and run of the jump game testbench

VERILATOR ?= verilator
TOP       ?= gameTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hdl/*.svh)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || { echo "No verdict in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
